// File: hw/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  localparam int mem_words     = 1024;
  localparam int mem_addr_bits = 10;

  localparam logic [1:0] axi_okay   = 2'b00;
  localparam logic [1:0] axi_slverr = 2'b10;

  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } acc_size_t;

  typedef enum logic [1:0] {
    status_ok         = 2'd0,
    status_bus_err    = 2'd1,
    status_misaligned = 2'd2
  } lsu_status_t;

  typedef struct packed {
    logic        is_store;
    acc_size_t   size;
    logic        sext;
    logic [31:0] addr;
    logic [31:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    lsu_status_t status;
  } lsu_resp_t;

  typedef struct packed {
    logic [31:0] addr;
  } axi_addr_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
  } axi_wdata_t;

  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } axi_rdata_t;

  typedef struct packed {
    logic [1:0] resp;
  } axi_bresp_t;

  // One bus word, by byte lane or by halfword lane
  typedef union packed {
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } bus_word_u;

  // Halfwords need an even address, words a 4-aligned one
  function automatic logic is_misaligned(acc_size_t size, logic [1:0] offset);
    case (size)
      size_half: return offset[0];
      size_word: return offset != 2'b00;
      default:   return 1'b0;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: hw/lsu_completion.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_completion import lsu_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      req_valid,
  input  lsu_req_t  req,
  input  logic      load_done,
  input  lsu_resp_t load_resp,
  input  logic      store_done,
  input  lsu_resp_t store_resp,
  output logic      req_ready,
  output lsu_req_t  cur_req,
  output logic      load_start,
  output logic      store_start,
  output logic      resp_valid,
  output lsu_resp_t resp
);

  logic busy;
  logic accept;

  assign req_ready = !busy;
  assign accept    = req_valid && req_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy        <= 1'b0;
      load_start  <= 1'b0;
      store_start <= 1'b0;
      resp_valid  <= 1'b0;
    end else begin
      load_start  <= accept && !req.is_store;
      store_start <= accept && req.is_store;
      resp_valid  <= load_done || store_done;
      if (accept) begin
        busy <= 1'b1;
      end else if (resp_valid) begin
        busy <= 1'b0; // Ready again after the response cycle
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      cur_req <= req;
    end
    if (load_done || store_done) begin
      resp <= load_done ? load_resp : store_resp;
    end
  end

  // Only the dispatched path may finish and only while busy
  done_excl: assert property (@(posedge clock) disable iff (reset)
    !(load_done && store_done) && ((load_done || store_done) -> busy));

endmodule

`default_nettype wire

// File: hw/lsu_load_path.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_load_path import lsu_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       load_start,
  input  lsu_req_t   cur_req,
  input  logic       arready,
  input  logic       rvalid,
  input  axi_rdata_t rdata,
  output logic       arvalid,
  output axi_addr_t  araddr,
  output logic       rready,
  output logic       load_done,
  output lsu_resp_t  load_resp
);

  typedef enum logic [1:0] {
    st_idle,
    st_addr,
    st_data,
    st_finish
  } state_t;

  state_t      state;
  lsu_resp_t   result;
  logic        misaligned;
  bus_word_u   word;
  logic [7:0]  lane_byte;
  logic [15:0] lane_half;
  logic [31:0] extended;

  assign misaligned = is_misaligned(cur_req.size, cur_req.addr[1:0]);

  assign word      = rdata.data;
  assign lane_byte = word.bytes[cur_req.addr[1:0]];
  assign lane_half = word.halves[cur_req.addr[1]];

  always_comb begin
    case (cur_req.size)
      size_byte: extended = {{24{cur_req.sext & lane_byte[7]}}, lane_byte};
      size_half: extended = {{16{cur_req.sext & lane_half[15]}}, lane_half};
      default:   extended = rdata.data;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (load_start && !misaligned) begin
            state <= st_addr;
          end
        end
        st_addr: begin
          if (arready) begin
            state <= st_data;
          end
        end
        st_data: begin
          if (rvalid) begin
            state <= st_finish;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_data && rvalid) begin
      if (rdata.resp == axi_okay) begin
        result.rdata  <= extended;
        result.status <= status_ok;
      end else begin
        result.rdata  <= '0;
        result.status <= status_bus_err;
      end
    end
  end

  assign arvalid = state == st_addr;
  assign araddr  = '{addr: cur_req.addr};
  assign rready  = state == st_data;

  // Misaligned loads finish in the start cycle
  assign load_done = (state == st_finish) || (state == st_idle && load_start && misaligned);

  always_comb begin
    if (state == st_finish) begin
      load_resp = result;
    end else begin
      load_resp.rdata  = '0;
      load_resp.status = status_misaligned;
    end
  end

  ar_hold: assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr));

endmodule

`default_nettype wire

// File: hw/lsu_store_path.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_store_path import lsu_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       store_start,
  input  lsu_req_t   cur_req,
  input  logic       awready,
  input  logic       wready,
  input  logic       bvalid,
  input  axi_bresp_t bresp,
  output logic       awvalid,
  output axi_addr_t  awaddr,
  output logic       wvalid,
  output axi_wdata_t wdata,
  output logic       bready,
  output logic       store_done,
  output lsu_resp_t  store_resp
);

  typedef enum logic [1:0] {
    st_idle,
    st_send,
    st_resp,
    st_finish
  } state_t;

  state_t      state;
  logic        aw_done;
  logic        w_done;
  logic        aw_fire;
  logic        w_fire;
  logic        misaligned;
  lsu_status_t result;
  bus_word_u   lanes;
  logic [3:0]  strb;

  assign misaligned = is_misaligned(cur_req.size, cur_req.addr[1:0]);

  // Data copied to every lane and the strobe picks one
  always_comb begin
    case (cur_req.size)
      size_byte: lanes.bytes  = {4{cur_req.wdata[7:0]}};
      size_half: lanes.halves = {2{cur_req.wdata[15:0]}};
      default:   lanes        = cur_req.wdata;
    endcase
  end

  always_comb begin
    case (cur_req.size)
      size_byte: strb = 4'b0001 << cur_req.addr[1:0];
      size_half: strb = 4'b0011 << {cur_req.addr[1], 1'b0};
      default:   strb = 4'b1111;
    endcase
  end

  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= st_idle;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (store_start && !misaligned) begin
            state <= st_send;
          end
        end
        st_send: begin
          if (aw_fire) begin
            aw_done <= 1'b1;
          end
          if (w_fire) begin
            w_done <= 1'b1;
          end
          if ((aw_done || aw_fire) && (w_done || w_fire)) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            state   <= st_resp;
          end
        end
        st_resp: begin
          if (bvalid) begin
            state <= st_finish;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_resp && bvalid) begin
      result <= (bresp.resp == axi_okay) ? status_ok : status_bus_err;
    end
  end

  assign awvalid = state == st_send && !aw_done;
  assign awaddr  = '{addr: cur_req.addr};
  assign wvalid  = state == st_send && !w_done;
  assign wdata   = {lanes, strb};
  assign bready  = state == st_resp;

  assign store_done = (state == st_finish) || (state == st_idle && store_start && misaligned);

  assign store_resp.rdata  = '0;
  assign store_resp.status = (state == st_finish) ? result : status_misaligned;

  w_hold: assert property (@(posedge clock) disable iff (reset)
    wvalid && !wready |=> wvalid && $stable(wdata));

endmodule

`default_nettype wire

// File: hw/axi_lite_sram.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_sram import lsu_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       arvalid,
  input  axi_addr_t  araddr,
  input  logic       rready,
  input  logic       awvalid,
  input  axi_addr_t  awaddr,
  input  logic       wvalid,
  input  axi_wdata_t wdata,
  input  logic       bready,
  output logic       arready,
  output logic       rvalid,
  output axi_rdata_t rdata,
  output logic       awready,
  output logic       wready,
  output logic       bvalid,
  output axi_bresp_t bresp
);

  logic [31:0] mem [mem_words];

  logic                     clearing;
  logic [mem_addr_bits-1:0] clear_idx;
  logic                     aw_got;
  logic                     w_got;
  axi_addr_t                aw_hold;
  axi_wdata_t               w_hold;
  logic                     ar_fire;
  logic                     aw_fire;
  logic                     w_fire;
  logic                     write_go;
  axi_addr_t                wr_addr;
  axi_wdata_t               wr_data;
  logic                     rd_in_range;
  logic                     wr_in_range;

  assign arready = !clearing && !rvalid;
  assign awready = !clearing && !bvalid && !aw_got;
  assign wready  = !clearing && !bvalid && !w_got;

  assign ar_fire = arvalid && arready;
  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;

  // AW and W may land in either order
  assign wr_addr  = aw_got ? aw_hold : awaddr;
  assign wr_data  = w_got ? w_hold : wdata;
  assign write_go = (aw_got || aw_fire) && (w_got || w_fire);

  assign rd_in_range = araddr.addr[31:mem_addr_bits+2] == '0;
  assign wr_in_range = wr_addr.addr[31:mem_addr_bits+2] == '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      clearing  <= 1'b1;
      clear_idx <= '0;
      rvalid    <= 1'b0;
      bvalid    <= 1'b0;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
    end else begin
      if (clearing) begin
        clear_idx <= clear_idx + 1'b1;
        if (clear_idx == mem_addr_bits'(mem_words - 1)) begin
          clearing <= 1'b0;
        end
      end
      if (ar_fire) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
      if (write_go) begin
        aw_got <= 1'b0;
        w_got  <= 1'b0;
        bvalid <= 1'b1;
      end else begin
        aw_got <= aw_got || aw_fire;
        w_got  <= w_got || w_fire;
        if (bready) begin
          bvalid <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (aw_fire) begin
      aw_hold <= awaddr;
    end
    if (w_fire) begin
      w_hold <= wdata;
    end
    if (ar_fire) begin
      rdata.data <= rd_in_range ? mem[araddr.addr[mem_addr_bits+1:2]] : '0;
      rdata.resp <= rd_in_range ? axi_okay : axi_slverr;
    end
    if (write_go) begin
      bresp.resp <= wr_in_range ? axi_okay : axi_slverr;
    end
  end

  always_ff @(posedge clock) begin
    if (clearing) begin
      mem[clear_idx] <= '0;
    end else if (write_go && wr_in_range) begin
      for (int i = 0; i < 4; i++) begin
        if (wr_data.strb[i]) begin
          mem[wr_addr.addr[mem_addr_bits+1:2]][8*i +: 8] <= wr_data.data[8*i +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      req_valid,
  input  lsu_req_t  req,
  output logic      req_ready,
  output logic      resp_valid,
  output lsu_resp_t resp
);

  lsu_req_t   cur_req;
  logic       load_start;
  logic       store_start;
  logic       load_done;
  logic       store_done;
  lsu_resp_t  load_resp;
  lsu_resp_t  store_resp;

  logic       arvalid;
  logic       arready;
  axi_addr_t  araddr;
  logic       rvalid;
  logic       rready;
  axi_rdata_t rdata;
  logic       awvalid;
  logic       awready;
  axi_addr_t  awaddr;
  logic       wvalid;
  logic       wready;
  axi_wdata_t wdata;
  logic       bvalid;
  logic       bready;
  axi_bresp_t bresp;

  lsu_completion u_completion (
    .clock       (clock),
    .reset       (reset),
    .req_valid   (req_valid),
    .req         (req),
    .load_done   (load_done),
    .load_resp   (load_resp),
    .store_done  (store_done),
    .store_resp  (store_resp),
    .req_ready   (req_ready),
    .cur_req     (cur_req),
    .load_start  (load_start),
    .store_start (store_start),
    .resp_valid  (resp_valid),
    .resp        (resp)
  );

  lsu_load_path u_load_path (
    .clock      (clock),
    .reset      (reset),
    .load_start (load_start),
    .cur_req    (cur_req),
    .arready    (arready),
    .rvalid     (rvalid),
    .rdata      (rdata),
    .arvalid    (arvalid),
    .araddr     (araddr),
    .rready     (rready),
    .load_done  (load_done),
    .load_resp  (load_resp)
  );

  lsu_store_path u_store_path (
    .clock       (clock),
    .reset       (reset),
    .store_start (store_start),
    .cur_req     (cur_req),
    .awready     (awready),
    .wready      (wready),
    .bvalid      (bvalid),
    .bresp       (bresp),
    .awvalid     (awvalid),
    .awaddr      (awaddr),
    .wvalid      (wvalid),
    .wdata       (wdata),
    .bready      (bready),
    .store_done  (store_done),
    .store_resp  (store_resp)
  );

  axi_lite_sram u_sram (
    .clock   (clock),
    .reset   (reset),
    .arvalid (arvalid),
    .araddr  (araddr),
    .rready  (rready),
    .awvalid (awvalid),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wdata   (wdata),
    .bready  (bready),
    .arready (arready),
    .rvalid  (rvalid),
    .rdata   (rdata),
    .awready (awready),
    .wready  (wready),
    .bvalid  (bvalid),
    .bresp   (bresp)
  );

endmodule

`default_nettype wire

// File: testbench/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

  localparam int timeout_cycles = 100;

  logic      clock;
  logic      reset;
  logic      req_valid;
  lsu_req_t  req;
  logic      req_ready;
  logic      resp_valid;
  lsu_resp_t resp;

  int pass_count;
  int fail_count;
  int op_errors;

  lsu_top DUT (
    .clock      (clock),
    .reset      (reset),
    .req_valid  (req_valid),
    .req        (req),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp       (resp)
  );

  always #5 clock = ~clock;

  task automatic check_status(input int op, input lsu_status_t expected,
                              input lsu_status_t actual);
    if (actual !== expected) begin
      $display("Error: op %0d resp.status expected %h got %h", op, expected, actual);
      op_errors++;
    end
  endtask

  task automatic check_rdata(input int op, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error: op %0d resp.rdata expected %h got %h", op, expected, actual);
      op_errors++;
    end
  endtask

  task automatic check_ready(input int op, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Error: op %0d req_ready expected %h got %h", op, expected, actual);
      op_errors++;
    end
  endtask

  // Starts 1 ns after a rising edge and returns at a falling edge
  task automatic run_op(input int op, input lsu_req_t r, input logic [31:0] exp_rdata,
                        input lsu_status_t exp_status, output bit hung);
    int        waited;
    logic      seen;
    lsu_resp_t got;
    hung      = 1'b0;
    op_errors = 0;
    req_valid = 1'b1;
    req       = r;
    waited    = 0;
    seen      = 1'b0;
    while (!seen && waited < timeout_cycles) begin
      @(negedge clock);
      waited++;
      seen = req_ready;
    end
    if (!seen) begin
      $display("Operation %0d was never accepted by the unit", op);
      req_valid = 1'b0;
      hung = 1'b1;
      fail_count++;
      return;
    end
    @(posedge clock); // Request transfers here
    #1;
    req_valid = 1'b0;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < timeout_cycles) begin
      @(negedge clock);
      waited++;
      seen = resp_valid;
    end
    if (!seen) begin
      $display("Operation %0d got no response within %0d cycles", op, timeout_cycles);
      hung = 1'b1;
      fail_count++;
      return;
    end
    got = resp;
    check_ready(op, 1'b0, req_ready);
    check_status(op, exp_status, got.status);
    if (!r.is_store && exp_status != status_misaligned) begin
      check_rdata(op, exp_rdata, got.rdata);
    end
    if (exp_status == status_misaligned && waited != 2) begin
      $display("Misaligned operation %0d responded after %0d cycles instead of 2", op, waited);
      op_errors++;
    end
    $display("op %0d %s size %0d addr %h status %0d rdata %h: %s", op,
             r.is_store ? "store" : "load ", r.size, r.addr, got.status, got.rdata,
             op_errors == 0 ? "ok" : "FAIL");
    if (op_errors == 0) begin
      pass_count++;
    end else begin
      fail_count++;
    end
  endtask

  initial begin
    int          fd;
    int          fields;
    int          op;
    int          waited;
    string       line;
    logic [31:0] f_store;
    logic [31:0] f_size;
    logic [31:0] f_sext;
    logic [31:0] f_addr;
    logic [31:0] f_wdata;
    logic [31:0] f_rdata;
    logic [31:0] f_status;
    lsu_req_t    r;
    bit          hung;
    bit          timed_out;

    clock      = 1'b0;
    reset      = 1'b1;
    req_valid  = 1'b0;
    req        = '0;
    pass_count = 0;
    fail_count = 0;
    op_errors  = 0;
    op         = 0;
    fd         = 0;
    timed_out  = 1'b0;

    repeat (10) @(posedge clock);
    #1;
    reset = 1'b0;

    waited = 0;
    while (!req_ready && waited < timeout_cycles) begin
      @(negedge clock);
      waited++;
    end
    if (!req_ready) begin
      $display("The unit never became ready after reset");
      timed_out = 1'b1;
      fail_count++;
    end

    repeat (mem_words + 4) @(posedge clock); // SRAM clears one word per cycle

    if (!timed_out) begin
      fd = $fopen("testbench/lsu_trace.txt", "r");
      if (fd == 0) begin
        $display("Could not open the trace file testbench/lsu_trace.txt");
        fail_count++;
      end
    end

    while (!timed_out && fd != 0 && !$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%h %h %h %h %h %h %h", f_store, f_size, f_sext,
                         f_addr, f_wdata, f_rdata, f_status);
        if (fields != 7) begin
          $display("Trace line after operation %0d could not be parsed", op);
          fail_count++;
        end else begin
          r.is_store = f_store[0];
          r.size     = acc_size_t'(f_size[1:0]);
          r.sext     = f_sext[0];
          r.addr     = f_addr;
          r.wdata    = f_wdata;
          @(posedge clock);
          #1;
          run_op(op, r, f_rdata, lsu_status_t'(f_status[1:0]), hung);
          timed_out = hung;
          op++;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    if (op == 0) begin
      $display("No operations were run from the trace");
      fail_count++;
    end

    $display("%0d operations passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0 && !timed_out) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/lsu_trace.txt
# is_store size(0 byte,1 half,2 word) sext addr wdata exp_rdata exp_status
# exp_status: 0 ok, 1 bus_err, 2 misaligned; exp_rdata is checked on loads only
0 2 0 00000100 00000000 00000000 0
0 2 0 00000ffc 00000000 00000000 0
1 2 0 00000010 deadbeef 00000000 0
0 2 0 00000010 00000000 deadbeef 0
1 2 0 00000020 11223344 00000000 0
1 0 0 00000021 000000aa 00000000 0
0 2 0 00000020 00000000 1122aa44 0
1 1 0 00000022 0000bbcc 00000000 0
0 2 0 00000020 00000000 bbccaa44 0
1 0 0 00000023 ffffff5a 00000000 0
0 2 0 00000020 00000000 5accaa44 0
1 2 0 00000030 80ff7f01 00000000 0
0 0 1 00000030 00000000 00000001 0
0 0 1 00000032 00000000 ffffffff 0
0 0 0 00000032 00000000 000000ff 0
0 0 1 00000033 00000000 ffffff80 0
0 0 0 00000033 00000000 00000080 0
0 0 1 00000031 00000000 0000007f 0
0 1 1 00000030 00000000 00007f01 0
0 1 1 00000032 00000000 ffff80ff 0
0 1 0 00000032 00000000 000080ff 0
1 1 0 00000041 12345678 00000000 2
1 2 0 00000042 12345678 00000000 2
0 1 1 00000031 00000000 00000000 2
0 2 0 00000033 00000000 00000000 2
0 2 0 00000040 00000000 00000000 0
1 2 0 00001000 cafef00d 00000000 1
0 2 0 00001000 00000000 00000000 1
0 0 1 80000004 00000000 00000000 1
1 0 0 00001003 000000ff 00000000 1
0 2 0 00000000 00000000 00000000 0

// File: filelist.f
hw/lsu_pkg.sv
hw/lsu_completion.sv
hw/lsu_load_path.sv
hw/lsu_store_path.sv
hw/axi_lite_sram.sv
hw/lsu_top.sv
testbench/lsu_tb.sv

// File: Makefile
SOURCES := $(shell cat filelist.f)

.PHONY: run clean

run: obj_dir/Vlsu_tb
	out=$$(./obj_dir/Vlsu_tb); echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

obj_dir/Vlsu_tb: filelist.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -f filelist.f

clean:
	rm -rf obj_dir
